// ==== compile.f ====
+incdir+.
rst_hk_pkg.sv
boot_delay.sv
reset_generator.sv
rst_release_counter.sv
rst_cfg_regs.sv
n64_rst_hk_top.sv
tb_n64_rst_hk.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the reset housekeeping testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_n64_rst_hk \
  -Mdir obj_dir \
  -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -qx "No errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb_n64_rst_hk.sv ====
// N64 reset housekeeping testbench
// Power-up order, gating, masks, software resets and register read-back
`include "rst_hk_params.svh"

module tb_n64_rst_hk;

  logic       N64_CLK_i = 1'b0;
  logic       arst_n_i;
  logic       n64_nrst_i;
  logic       hdmi_cfg_done_i;
  logic       pll_locked_i;
  logic       cfg_we_i;
  logic       cfg_re_i;
  logic [2:0] cfg_addr_i;
  logic [7:0] cfg_wdata_i;
  logic [7:0] cfg_rdata_o;
  logic       cfg_rvalid_o;
  logic       ppu_nrst_o;
  logic       hdmi_nrst_o;
  logic       dram_nrst_o;
  logic       aud_nrst_o;
  logic [3:0] rst_vec;

  // Reference state
  logic [1:0] ctrl_sh = '0;
  logic [3:0] soft_sh = '0;
  logic [7:0] ref_cnt [4];
  logic [3:0] prev_obs;
  logic [3:0] rise_pend;
  logic       rd_pend;
  logic [7:0] rd_exp;
  int         cyc;
  int         seed = 10;
  int         err_main = 0;
  int         err_cmp = 0;
  string      test_name = "init";

  always #5 N64_CLK_i = ~N64_CLK_i;

  n64_rst_hk_top dut_i (.*);

  // Bit order PPU, HDMI, DRAM, audio
  assign rst_vec = {aud_nrst_o, dram_nrst_o, hdmi_nrst_o, ppu_nrst_o};

  // Clock edges since system reset release
  always @(posedge N64_CLK_i) begin
    if (!arst_n_i) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Expected read data from shadows, observed resets and boot timing
  function automatic logic [7:0] ref_rdata(input logic [2:0] addr);
    logic boot_exp;
    boot_exp = (cyc >= `BOOT_DELAY_CYCLES);
    case (addr)
      `ADDR_CTRL:            return {6'd0, ctrl_sh};
      `ADDR_SOFT:            return {4'd0, soft_sh};
      `ADDR_STATUS:          return {3'd0, boot_exp, rst_vec};
      `ADDR_CNT_BASE:        return ref_cnt[0];
      `ADDR_CNT_BASE + 3'd1: return ref_cnt[1];
      `ADDR_CNT_BASE + 3'd2: return ref_cnt[2];
      `ADDR_CNT_BASE + 3'd3: return ref_cnt[3];
      default:               return 8'd0;
    endcase
  endfunction

  // Returns 1 on a mismatch
  function automatic int check_val(input string what, input logic [7:0] exp_v,
                                   input logic [7:0] act_v);
    int bad;
    bad = 0;
    assert (exp_v == act_v) else begin
      $display("Mismatch %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp_v, act_v);
      bad = 1;
    end
    return bad;
  endfunction

  function automatic string dom_name(input logic [1:0] d);
    case (d)
      2'd0:    return "PPU";
      2'd1:    return "HDMI";
      2'd2:    return "DRAM";
      default: return "audio";
    endcase
  endfunction

  //////////////////////////////
  // Compare process
  //////////////////////////////

  // Counter model lags a release by one cycle, like the status counters
  always @(negedge N64_CLK_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 4; i++) begin
        ref_cnt[i] = '0;
      end
      prev_obs  = '0;
      rise_pend = '0;
      rd_pend   = 1'b0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (rise_pend[i]) begin
          ref_cnt[i] = ref_cnt[i] + 8'd1;
        end
      end
      rise_pend = rst_vec & ~prev_obs;
      prev_obs  = rst_vec;
      // Valid strobe exactly one cycle after each read strobe
      if (rd_pend) begin
        assert (cfg_rvalid_o) else begin
          $display("Read valid missing on the cycle after a read strobe in %s", test_name);
          err_cmp++;
        end
        if (cfg_rvalid_o) begin
          err_cmp += check_val("cfg_rdata_o", rd_exp, cfg_rdata_o);
        end
      end else begin
        assert (!cfg_rvalid_o) else begin
          $display("Read valid seen without a read strobe in %s", test_name);
          err_cmp++;
        end
      end
      // Mux is captured on the coming edge
      rd_pend = cfg_re_i;
      if (cfg_re_i) begin
        rd_exp = ref_rdata(cfg_addr_i);
      end
    end
  end

  //////////////////////////////
  // Bus and wait tasks
  //////////////////////////////

  task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
    @(posedge N64_CLK_i);
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= data;
    @(posedge N64_CLK_i);
    cfg_we_i <= 1'b0;
    // Register takes the value on this edge
    if (addr == `ADDR_CTRL) begin
      ctrl_sh = data[1:0];
    end else if (addr == `ADDR_SOFT) begin
      soft_sh = data[3:0];
    end
  endtask

  task automatic read_reg(input logic [2:0] addr);
    int n;
    n = 0;
    @(posedge N64_CLK_i);
    cfg_re_i   <= 1'b1;
    cfg_addr_i <= addr;
    @(posedge N64_CLK_i);
    cfg_re_i <= 1'b0;
    @(negedge N64_CLK_i);
    while (!cfg_rvalid_o && n < 8) begin
      @(negedge N64_CLK_i);
      n++;
    end
    if (!cfg_rvalid_o) begin
      $display("Timeout waiting for read data from address %0d", addr);
      err_main++;
    end
  endtask

  task automatic wait_rst(input logic [1:0] d, input int max_cyc);
    int n;
    n = 0;
    @(negedge N64_CLK_i);
    while (!rst_vec[d] && n < max_cyc) begin
      @(negedge N64_CLK_i);
      n++;
    end
    if (!rst_vec[d]) begin
      $display("Timeout waiting for the %s reset to release", dom_name(d));
      err_main++;
    end
  endtask

  task automatic check_hold(input logic [3:0] exp_v, input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge N64_CLK_i);
      err_main += check_val("reset outputs", {4'd0, exp_v}, {4'd0, rst_vec});
    end
  endtask

  // Console reset low for one cycle, resets checked while it is low
  task automatic pulse_console(input logic [3:0] exp_v);
    @(posedge N64_CLK_i);
    n64_nrst_i <= 1'b0;
    @(negedge N64_CLK_i);
    err_main += check_val("resets during console reset", {4'd0, exp_v}, {4'd0, rst_vec});
    @(posedge N64_CLK_i);
    n64_nrst_i <= 1'b1;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    logic [1:0]  d;
    logic [3:0]  soft_bit;
    logic [31:0] r;
    arst_n_i        <= 1'b0;
    n64_nrst_i      <= 1'b1;
    hdmi_cfg_done_i <= 1'b0;
    pll_locked_i    <= 1'b0;
    cfg_we_i        <= 1'b0;
    cfg_re_i        <= 1'b0;
    cfg_addr_i      <= '0;
    cfg_wdata_i     <= '0;
    repeat (5) @(posedge N64_CLK_i);
    arst_n_i <= 1'b1;

    // Boot delay, then enabled sync and stretch cycles
    test_name = "power_up";
    @(negedge N64_CLK_i);
    err_main += check_val("resets after system reset", 8'h00, {4'd0, rst_vec});
    read_reg(`ADDR_STATUS);
    wait_rst(2'd0, 100);
    err_main += check_val("PPU release cycle",
                          8'(`BOOT_DELAY_CYCLES + 2 + `RST_LEN_PPU), 8'(cyc));
    wait_rst(2'd3, 100);
    err_main += check_val("audio release cycle",
                          8'(`BOOT_DELAY_CYCLES + 2 + `RST_LEN_DEFAULT), 8'(cyc));
    read_reg(`ADDR_STATUS);
    // DRAM waits for the PLL
    check_hold(4'b1001, 10);
    @(posedge N64_CLK_i);
    pll_locked_i <= 1'b1;
    wait_rst(2'd2, 50);

    test_name = "hdmi_gate";
    check_hold(4'b1101, 20);
    @(posedge N64_CLK_i);
    hdmi_cfg_done_i <= 1'b1;
    wait_rst(2'd1, 50);
    read_reg(`ADDR_STATUS);

    // Unmasked pulse hits video and audio, masked pulse hits nothing
    test_name = "console_rst";
    pulse_console(4'b0100);
    wait_rst(2'd0, 50);
    wait_rst(2'd1, 50);
    wait_rst(2'd3, 50);
    write_reg(`ADDR_CTRL, 8'h03);
    read_reg(`ADDR_CTRL);
    pulse_console(4'b1111);
    check_hold(4'b1111, 12);
    write_reg(`ADDR_CTRL, 8'h00);

    test_name = "soft_rst";
    for (int i = 0; i < 4; i++) begin
      d        = 2'(i);
      soft_bit = 4'b0001 << d;
      write_reg(`ADDR_SOFT, {4'd0, soft_bit});
      @(negedge N64_CLK_i);
      err_main += check_val("soft reset outputs", {4'd0, ~soft_bit}, {4'd0, rst_vec});
      read_reg(`ADDR_SOFT);
      write_reg(`ADDR_SOFT, 8'h00);
      wait_rst(d, 50);
    end
    repeat (2) @(posedge N64_CLK_i);
    for (int k = 0; k < 4; k++) begin
      read_reg(`ADDR_CNT_BASE + 3'(k));
    end

    // Mixed traffic, includes ignored writes and unused reads
    test_name = "random_regs";
    for (int n = 0; n < 60; n++) begin
      r = $random(seed);
      case (r[2:0])
        3'd0:    write_reg(`ADDR_CTRL, r[15:8]);
        3'd1:    write_reg(`ADDR_SOFT, r[15:8]);
        3'd2:    read_reg(`ADDR_CTRL);
        3'd3:    read_reg(`ADDR_SOFT);
        3'd4:    read_reg(3'd7);
        3'd5:    read_reg(`ADDR_STATUS);
        3'd6:    write_reg(r[18:16], r[15:8]);
        default: read_reg(r[18:16]);
      endcase
    end
    write_reg(`ADDR_SOFT, 8'h00);
    write_reg(`ADDR_CTRL, 8'h00);
    for (int i = 0; i < 4; i++) begin
      wait_rst(2'(i), 50);
    end
    repeat (2) @(posedge N64_CLK_i);
    for (int k = 0; k < 4; k++) begin
      read_reg(`ADDR_CNT_BASE + 3'(k));
    end
    read_reg(`ADDR_STATUS);

    repeat (3) @(posedge N64_CLK_i);
    $display("Error counts: directed %0d, read compare %0d", err_main, err_cmp);
    if (err_main == 0 && err_cmp == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== n64_rst_hk_top.sv ====
// N64 reset housekeeping top
// Builds PPU, HDMI, DRAM and audio resets with boot delay and register control
`include "rst_hk_params.svh"

module n64_rst_hk_top (
  input  logic                  N64_CLK_i,
  input  logic                  arst_n_i,
  input  logic                  n64_nrst_i,
  input  logic                  hdmi_cfg_done_i,
  input  logic                  pll_locked_i,
  input  logic                  cfg_we_i,
  input  logic                  cfg_re_i,
  input  rst_hk_pkg::cfg_addr_t cfg_addr_i,
  input  rst_hk_pkg::cfg_data_t cfg_wdata_i,
  output rst_hk_pkg::cfg_data_t cfg_rdata_o,
  output logic                  cfg_rvalid_o,
  output logic                  ppu_nrst_o,
  output logic                  hdmi_nrst_o,
  output logic                  dram_nrst_o,
  output logic                  aud_nrst_o
);
  import rst_hk_pkg::*;

  logic        boot_done_w;
  logic        mask_video_w;
  logic        mask_audio_w;
  domain_vec_t soft_rst_w;
  domain_vec_t dom_rst_w;
  rel_cnt_t    cnt_ppu_w;
  rel_cnt_t    cnt_hdmi_w;
  rel_cnt_t    cnt_dram_w;
  rel_cnt_t    cnt_aud_w;
  logic        nrst_video_masked_w;
  logic        nrst_audio_masked_w;

  //////////////////////////////
  // Reset sources
  //////////////////////////////

  // Mask bit set keeps console reset away from that path
  assign nrst_video_masked_w = n64_nrst_i | mask_video_w;
  assign nrst_audio_masked_w = n64_nrst_i | mask_audio_w;

  boot_delay boot_delay_u (
    .N64_CLK_i   (N64_CLK_i),
    .arst_n_i    (arst_n_i),
    .boot_done_o (boot_done_w)
  );

  //////////////////////////////
  // Domain resets
  //////////////////////////////

  // PPU, runs once boot is done
  reset_generator #(.RST_LENGTH(`RST_LEN_PPU)) reset_ppu_u (
    .N64_CLK_i    (N64_CLK_i),
    .arst_n_i     (arst_n_i),
    .clk_en_i     (boot_done_w),
    .async_nrst_i (nrst_video_masked_w & ~soft_rst_w[0]),
    .rst_o        (ppu_nrst_o)
  );

  // HDMI, also held until transmitter config is done
  reset_generator #(.RST_LENGTH(`RST_LEN_DEFAULT)) reset_hdmi_u (
    .N64_CLK_i    (N64_CLK_i),
    .arst_n_i     (arst_n_i),
    .clk_en_i     (1'b1),
    .async_nrst_i (nrst_video_masked_w & hdmi_cfg_done_i & ~soft_rst_w[1]),
    .rst_o        (hdmi_nrst_o)
  );

  // DRAM, source is boot-done, enable stands in for PLL clock
  reset_generator #(.RST_LENGTH(`RST_LEN_DEFAULT)) reset_dram_u (
    .N64_CLK_i    (N64_CLK_i),
    .arst_n_i     (arst_n_i),
    .clk_en_i     (pll_locked_i),
    .async_nrst_i (boot_done_w & ~soft_rst_w[2]),
    .rst_o        (dram_nrst_o)
  );

  // Audio
  reset_generator #(.RST_LENGTH(`RST_LEN_DEFAULT)) reset_aud_u (
    .N64_CLK_i    (N64_CLK_i),
    .arst_n_i     (arst_n_i),
    .clk_en_i     (boot_done_w),
    .async_nrst_i (nrst_audio_masked_w & ~soft_rst_w[3]),
    .rst_o        (aud_nrst_o)
  );

  assign dom_rst_w = {aud_nrst_o, dram_nrst_o, hdmi_nrst_o, ppu_nrst_o};

  //////////////////////////////
  // Status and control
  //////////////////////////////

  rst_release_counter rst_release_counter_u (
    .N64_CLK_i  (N64_CLK_i),
    .arst_n_i   (arst_n_i),
    .dom_rst_i  (dom_rst_w),
    .cnt_ppu_o  (cnt_ppu_w),
    .cnt_hdmi_o (cnt_hdmi_w),
    .cnt_dram_o (cnt_dram_w),
    .cnt_aud_o  (cnt_aud_w)
  );

  rst_cfg_regs rst_cfg_regs_u (
    .N64_CLK_i    (N64_CLK_i),
    .arst_n_i     (arst_n_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_re_i     (cfg_re_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_rdata_o  (cfg_rdata_o),
    .cfg_rvalid_o (cfg_rvalid_o),
    .mask_video_o (mask_video_w),
    .mask_audio_o (mask_audio_w),
    .soft_rst_o   (soft_rst_w),
    .dom_rst_i    (dom_rst_w),
    .boot_done_i  (boot_done_w),
    .cnt_ppu_i    (cnt_ppu_w),
    .cnt_hdmi_i   (cnt_hdmi_w),
    .cnt_dram_i   (cnt_dram_w),
    .cnt_aud_i    (cnt_aud_w)
  );

endmodule

// ==== rst_cfg_regs.sv ====
// Reset configuration registers
// Masks and software resets, status and release counter read-back
`include "rst_hk_params.svh"

module rst_cfg_regs (
  input  logic                    N64_CLK_i,
  input  logic                    arst_n_i,
  input  logic                    cfg_we_i,
  input  logic                    cfg_re_i,
  input  rst_hk_pkg::cfg_addr_t   cfg_addr_i,
  input  rst_hk_pkg::cfg_data_t   cfg_wdata_i,
  output rst_hk_pkg::cfg_data_t   cfg_rdata_o,
  output logic                    cfg_rvalid_o,
  output logic                    mask_video_o,
  output logic                    mask_audio_o,
  output rst_hk_pkg::domain_vec_t soft_rst_o,
  input  rst_hk_pkg::domain_vec_t dom_rst_i,
  input  logic                    boot_done_i,
  input  rst_hk_pkg::rel_cnt_t    cnt_ppu_i,
  input  rst_hk_pkg::rel_cnt_t    cnt_hdmi_i,
  input  rst_hk_pkg::rel_cnt_t    cnt_dram_i,
  input  rst_hk_pkg::rel_cnt_t    cnt_aud_i
);
  import rst_hk_pkg::*;

  logic [1:0]  ctrl_q;
  domain_vec_t soft_q;
  cfg_data_t   rdata_mux_w;
  cfg_data_t   rdata_q;
  logic        rvalid_q;

  // Write decode, read-only and unused addresses fall through
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q <= '0;
      soft_q <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        `ADDR_CTRL: ctrl_q <= cfg_wdata_i[1:0];
        `ADDR_SOFT: soft_q <= cfg_wdata_i[3:0];
        default: ;
      endcase
    end
  end

  // Read mux
  // Status bit 4 is boot-done, bits 3:0 live resets
  always_comb begin
    rdata_mux_w = '0;
    case (cfg_addr_i)
      `ADDR_CTRL:            rdata_mux_w = {6'd0, ctrl_q};
      `ADDR_SOFT:            rdata_mux_w = {4'd0, soft_q};
      `ADDR_STATUS:          rdata_mux_w = {3'd0, boot_done_i, dom_rst_i};
      `ADDR_CNT_BASE:        rdata_mux_w = cnt_ppu_i;
      `ADDR_CNT_BASE + 3'd1: rdata_mux_w = cnt_hdmi_i;
      `ADDR_CNT_BASE + 3'd2: rdata_mux_w = cnt_dram_i;
      `ADDR_CNT_BASE + 3'd3: rdata_mux_w = cnt_aud_i;
      default:               rdata_mux_w = '0;
    endcase
  end

  // Read strobe, one cycle latency
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= cfg_re_i;
    end
  end

  // Read data captured with the strobe
  always_ff @(posedge N64_CLK_i) begin
    if (cfg_re_i) begin
      rdata_q <= rdata_mux_w;
    end
  end

  assign cfg_rdata_o  = rdata_q;
  assign cfg_rvalid_o = rvalid_q;
  assign mask_video_o = ctrl_q[0];
  assign mask_audio_o = ctrl_q[1];
  assign soft_rst_o   = soft_q;

endmodule

// ==== rst_release_counter.sv ====
// Reset release history
// Counts rising edges of each domain reset for status read-back
module rst_release_counter (
  input  logic                   N64_CLK_i,
  input  logic                   arst_n_i,
  input  rst_hk_pkg::domain_vec_t dom_rst_i,
  output rst_hk_pkg::rel_cnt_t    cnt_ppu_o,
  output rst_hk_pkg::rel_cnt_t    cnt_hdmi_o,
  output rst_hk_pkg::rel_cnt_t    cnt_dram_o,
  output rst_hk_pkg::rel_cnt_t    cnt_aud_o
);
  import rst_hk_pkg::*;

  localparam int N_DOM = $bits(domain_vec_t);

  domain_vec_t prev_q;
  domain_vec_t rise_w;
  rel_cnt_t    cnt_q [N_DOM];

  // Release is a low to high step of the active low reset
  assign rise_w = dom_rst_i & ~prev_q;

  // One wrapping counter per domain
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prev_q <= '0;
      for (int i = 0; i < N_DOM; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      prev_q <= dom_rst_i;
      for (int i = 0; i < N_DOM; i++) begin
        if (rise_w[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Bit order PPU, HDMI, DRAM, audio
  assign cnt_ppu_o  = cnt_q[0];
  assign cnt_hdmi_o = cnt_q[1];
  assign cnt_dram_o = cnt_q[2];
  assign cnt_aud_o  = cnt_q[3];

endmodule

// ==== reset_generator.sv ====
// Domain reset generator
// Asynchronous assert, synchronized and stretched release on clock enable
module reset_generator #(
  parameter int RST_LENGTH = 8
) (
  input  logic N64_CLK_i,
  input  logic arst_n_i,
  input  logic clk_en_i,
  input  logic async_nrst_i,
  output logic rst_o
);
  import rst_hk_pkg::*;

  // Stretch counter runs 1 .. RST_LENGTH-1
  localparam int CNT_W = (RST_LENGTH > 1) ? $clog2(RST_LENGTH) : 1;

  logic             nrst_w;
  logic [1:0]       sync_q;
  rg_state_t        state_q;
  logic [CNT_W-1:0] cnt_q;

  // Either system reset or domain source pulls the reset
  assign nrst_w = arst_n_i & async_nrst_i;

  // Two-flop synchronizer, shifts only on enabled cycles
  always_ff @(posedge N64_CLK_i or negedge nrst_w) begin
    if (!nrst_w) begin
      sync_q <= '0;
    end else if (clk_en_i) begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Release stretch FSM
  // Leaving hold counts as the first stretch cycle
  // A source drop resets everything, so the count restarts
  always_ff @(posedge N64_CLK_i or negedge nrst_w) begin
    if (!nrst_w) begin
      state_q <= RG_HOLD;
      cnt_q   <= '0;
    end else if (clk_en_i) begin
      case (state_q)
        RG_HOLD: begin
          if (sync_q[1]) begin
            cnt_q <= CNT_W'(1);
            if (RST_LENGTH > 1) begin
              state_q <= RG_STRETCH;
            end else begin
              state_q <= RG_RUN;
            end
          end
        end
        RG_STRETCH: begin
          if (cnt_q == CNT_W'(RST_LENGTH - 1)) begin
            state_q <= RG_RUN;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RG_RUN:  state_q <= RG_RUN;
        default: state_q <= RG_HOLD;
      endcase
    end
  end

  // Active low reset, released only in run
  assign rst_o = (state_q == RG_RUN);

endmodule

// ==== boot_delay.sv ====
// Power-up boot delay
// Raises boot-done a fixed number of cycles after system reset release
`include "rst_hk_params.svh"

module boot_delay (
  input  logic N64_CLK_i,
  input  logic arst_n_i,
  output logic boot_done_o
);
  import rst_hk_pkg::*;

  // Room for the full delay value
  localparam int CNT_W = $clog2(`BOOT_DELAY_CYCLES + 1);

  boot_state_t      state_q;
  logic [CNT_W-1:0] cnt_q;

  // Counter starts at delay minus one
  // Transition to done happens on the edge after it hits zero
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BOOT_WAIT;
      cnt_q   <= CNT_W'(`BOOT_DELAY_CYCLES - 1);
    end else begin
      case (state_q)
        BOOT_WAIT: begin
          if (cnt_q == '0) begin
            state_q <= BOOT_DONE;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        // Sticky until next system reset
        BOOT_DONE: state_q <= BOOT_DONE;
      endcase
    end
  end

  assign boot_done_o = (state_q == BOOT_DONE);

endmodule

// ==== rst_hk_pkg.sv ====
// Reset housekeeping types
// Domain vectors, register bus words and FSM encodings
package rst_hk_pkg;

  // One bit per reset domain
  // Bit 0 PPU, bit 1 HDMI, bit 2 DRAM, bit 3 audio
  typedef logic [3:0] domain_vec_t;

  // Register bus address and data
  typedef logic [2:0] cfg_addr_t;
  typedef logic [7:0] cfg_data_t;

  // Release event count, wraps on overflow
  typedef logic [7:0] rel_cnt_t;

  // Power-up delay FSM
  typedef enum logic {
    BOOT_WAIT,
    BOOT_DONE
  } boot_state_t;

  // Reset generator FSM
  // Hold while source low, stretch after sync, run when released
  typedef enum logic [1:0] {
    RG_HOLD,
    RG_STRETCH,
    RG_RUN
  } rg_state_t;

endpackage

// ==== rst_hk_params.svh ====
// Reset housekeeping constants
// Boot delay, reset stretch lengths and register map
`ifndef RST_HK_PARAMS_SVH
`define RST_HK_PARAMS_SVH

//////////////////////////////
// Timing
//////////////////////////////

// Cycles from system reset release until boot-done
`define BOOT_DELAY_CYCLES 32

// Enabled cycles of release stretch after the synchronizer
`define RST_LEN_PPU       4
`define RST_LEN_DEFAULT   8

//////////////////////////////
// Register map
//////////////////////////////

`define ADDR_CTRL         3'd0
`define ADDR_SOFT         3'd1
`define ADDR_STATUS       3'd2
// Release counters follow in order PPU, HDMI, DRAM, audio
`define ADDR_CNT_BASE     3'd3

`endif
